//--- src/ex_pkg.sv
package ex_pkg;

    parameter int XLEN   = 64;  // data and address width
    parameter int REG_AW = 5;   // register index width
    parameter int INST_W = 32;

    // major opcodes handled by this stage
    parameter logic [6:0] OPC_OP_IMM   = 7'b0010011;
    parameter logic [6:0] OPC_OP_IMM_W = 7'b0011011;
    parameter logic [6:0] OPC_OP       = 7'b0110011;
    parameter logic [6:0] OPC_OP_W     = 7'b0111011;
    parameter logic [6:0] OPC_BRANCH   = 7'b1100011;
    parameter logic [6:0] OPC_STORE    = 7'b0100011;
    parameter logic [6:0] OPC_JAL      = 7'b1101111;
    parameter logic [6:0] OPC_JALR     = 7'b1100111;
    parameter logic [6:0] OPC_LUI      = 7'b0110111;
    parameter logic [6:0] OPC_AUIPC    = 7'b0010111;

    // alu group, shared by register and immediate forms
    parameter logic [2:0] F3_ADD_SUB = 3'b000;
    parameter logic [2:0] F3_SLL     = 3'b001;
    parameter logic [2:0] F3_SLT     = 3'b010;
    parameter logic [2:0] F3_SLTU    = 3'b011;
    parameter logic [2:0] F3_XOR     = 3'b100;
    parameter logic [2:0] F3_SR      = 3'b101;  // srl and sra
    parameter logic [2:0] F3_OR      = 3'b110;
    parameter logic [2:0] F3_AND     = 3'b111;

    // branch group
    parameter logic [2:0] F3_BEQ  = 3'b000;
    parameter logic [2:0] F3_BNE  = 3'b001;
    parameter logic [2:0] F3_BLT  = 3'b100;
    parameter logic [2:0] F3_BGE  = 3'b101;
    parameter logic [2:0] F3_BLTU = 3'b110;
    parameter logic [2:0] F3_BGEU = 3'b111;

    // store group, low two bits give log2 of the byte count
    parameter logic [2:0] F3_SB = 3'b000;
    parameter logic [2:0] F3_SH = 3'b001;
    parameter logic [2:0] F3_SW = 3'b010;
    parameter logic [2:0] F3_SD = 3'b011;

    parameter logic [2:0] F3_JALR = 3'b000;

    typedef struct packed {
        logic [6:0]        func7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        func3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]       imm12;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        func3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } inst_i_t;

    // same word, seen as R format or I format
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef enum logic [2:0] {
        KIND_NONE,
        KIND_ALU,
        KIND_BRANCH,
        KIND_STORE,
        KIND_JUMP
    } op_kind_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
        ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_e;

    typedef struct packed {
        inst_u             inst;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   op1;
        logic [XLEN-1:0]   op2;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   base;
        logic [XLEN-1:0]   offset;
    } ex_in_t;

    typedef struct packed {
        op_kind_e          kind;
        alu_op_e           alu_op;
        logic              word;     // 32-bit form
        br_cond_e          br_cond;
        logic [1:0]        st_size;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   op1;
        logic [XLEN-1:0]   op2;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   base;
        logic [XLEN-1:0]   offset;
    } dec_t;

    typedef struct packed {
        op_kind_e          kind;
        logic              word;
        logic [1:0]        st_size;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   result;
        logic              taken;
        logic [XLEN-1:0]   addr;     // base + offset
        logic [XLEN-1:0]   sdata;    // op2, raw store data
    } alu_t;

    typedef struct packed {
        logic              wen;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
    } wb_t;

    typedef struct packed {
        logic            en;
        logic [XLEN-1:0] addr;
    } jump_t;

    typedef struct packed {
        logic            wen;
        logic [XLEN-1:0] waddr;
        logic [XLEN-1:0] wdata;
        logic [7:0]      wmask;
    } mem_wr_t;

endpackage

//--- src/ex_decode.sv
`timescale 1ns/100ps

module ex_decode import ex_pkg::*; (
    input  logic   clk_i,
    input  logic   arst_n_i,
    input  ex_in_t in_i,
    output dec_t   dec_o
);

    inst_u      ins;
    logic [6:0] opc;
    logic [2:0] f3;
    logic       imm_grp;   // op-imm or op-imm-32
    logic       word_grp;  // the *w forms
    logic       alt_bit;   // sub / sra selector
    op_kind_e   kind;
    alu_op_e    alu_op;
    br_cond_e   br_cond;

    assign ins      = in_i.inst;
    assign opc      = ins.r.opcode;
    assign f3       = ins.r.func3;
    assign imm_grp  = (opc == OPC_OP_IMM) || (opc == OPC_OP_IMM_W);
    assign word_grp = (opc == OPC_OP_IMM_W) || (opc == OPC_OP_W);
    // bit 30 either way, but immediates keep it inside imm12
    assign alt_bit  = imm_grp ? ins.i.imm12[10] : ins.r.func7[5];

    always_comb begin
        kind    = KIND_NONE;
        alu_op  = ALU_ADD;
        br_cond = BR_EQ;
        case (opc)
            OPC_OP_IMM, OPC_OP_IMM_W, OPC_OP, OPC_OP_W: begin
                kind = KIND_ALU;
                case (f3)
                    F3_ADD_SUB: alu_op = (alt_bit && !imm_grp) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     alu_op = ALU_SLL;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SR:      alu_op = alt_bit ? ALU_SRA : ALU_SRL;
                    F3_OR:      alu_op = ALU_OR;
                    default:    alu_op = ALU_AND;
                endcase
                // word forms only have add/sub and the shifts
                if (word_grp && !(f3 == F3_ADD_SUB || f3 == F3_SLL || f3 == F3_SR)) begin
                    kind = KIND_NONE;
                end
            end
            OPC_BRANCH: begin
                kind = KIND_BRANCH;
                case (f3)
                    F3_BEQ:  br_cond = BR_EQ;
                    F3_BNE:  br_cond = BR_NE;
                    F3_BLT:  br_cond = BR_LT;
                    F3_BGE:  br_cond = BR_GE;
                    F3_BLTU: br_cond = BR_LTU;
                    F3_BGEU: br_cond = BR_GEU;
                    default: kind    = KIND_NONE;  // 010, 011 unused
                endcase
            end
            OPC_STORE: begin
                kind = f3[2] ? KIND_NONE : KIND_STORE;  // sb..sd only
            end
            OPC_JAL: begin
                kind = KIND_JUMP;  // rd = op1 + op2 (pc + 4)
            end
            OPC_JALR: begin
                kind = (f3 == F3_JALR) ? KIND_JUMP : KIND_NONE;
            end
            OPC_LUI: begin
                kind   = KIND_ALU;
                alu_op = ALU_PASS_B;  // op2 already holds the shifted imm
            end
            OPC_AUIPC: begin
                kind = KIND_ALU;  // pc + imm
            end
            default: begin
                kind = KIND_NONE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_o <= '0;
        end else begin
            dec_o.kind    <= kind;
            dec_o.alu_op  <= alu_op;
            dec_o.word    <= word_grp;
            dec_o.br_cond <= br_cond;
            dec_o.st_size <= f3[1:0];
            dec_o.pc      <= in_i.pc;
            dec_o.op1     <= in_i.op1;
            dec_o.op2     <= in_i.op2;
            dec_o.rd      <= in_i.rd;
            dec_o.base    <= in_i.base;
            dec_o.offset  <= in_i.offset;
        end
    end

endmodule

//--- src/ex_alu.sv
`timescale 1ns/100ps

module ex_alu import ex_pkg::*; (
    input  logic clk_i,
    input  logic arst_n_i,
    input  dec_t dec_i,
    output alu_t alu_o
);

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [5:0]      shamt;
    logic [XLEN-1:0] sh_src;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] sll_res;
    logic [XLEN-1:0] srl_res;
    logic [XLEN-1:0] sra_res;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] result;
    logic            taken;

    assign op1 = dec_i.op1;
    assign op2 = dec_i.op2;

    // rv64 masks to 6 bits, word forms to 5
    assign shamt = dec_i.word ? {1'b0, op2[4:0]} : op2[5:0];

    // word shifts work on the low word, widened to suit the shift kind
    assign sh_src = dec_i.word ?
                    {{32{(dec_i.alu_op == ALU_SRA) && op1[31]}}, op1[31:0]} : op1;

    assign sum     = op1 + op2;
    assign diff    = op1 - op2;
    assign sll_res = op1 << shamt;  // low word is all that matters for sllw
    assign srl_res = sh_src >> shamt;
    assign sra_res = $signed(sh_src) >>> shamt;

    assign eq   = (op1 == op2);
    assign lt_s = ($signed(op1) < $signed(op2));
    assign lt_u = (op1 < op2);

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    result = sum;
            ALU_SUB:    result = diff;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:    result = op1 ^ op2;
            ALU_OR:     result = op1 | op2;
            ALU_AND:    result = op1 & op2;
            ALU_SLL:    result = sll_res;
            ALU_SRL:    result = srl_res;
            ALU_SRA:    result = sra_res;
            ALU_PASS_B: result = op2;  // lui
            default:    result = '0;
        endcase
    end

    always_comb begin
        case (dec_i.br_cond)
            BR_EQ:   taken = eq;
            BR_NE:   taken = !eq;
            BR_LT:   taken = lt_s;
            BR_GE:   taken = !lt_s;
            BR_LTU:  taken = lt_u;
            BR_GEU:  taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alu_o <= '0;
        end else begin
            alu_o.kind    <= dec_i.kind;
            alu_o.word    <= dec_i.word;
            alu_o.st_size <= dec_i.st_size;
            alu_o.pc      <= dec_i.pc;
            alu_o.rd      <= dec_i.rd;
            alu_o.result  <= result;
            alu_o.taken   <= taken;
            alu_o.addr    <= dec_i.base + dec_i.offset;  // branch, jump and store target
            alu_o.sdata   <= op2;
        end
    end

endmodule

//--- src/ex_commit.sv
`timescale 1ns/100ps

module ex_commit import ex_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  alu_t            alu_i,
    output wb_t             wb_o,
    output jump_t           jump_o,
    output mem_wr_t         mem_o,
    output logic [XLEN-1:0] pc_o
);

    logic [XLEN-1:0] wdata;
    logic [7:0]      wmask;
    logic [XLEN-1:0] sdata;
    wb_t             wb_d;
    jump_t           jump_d;
    mem_wr_t         mem_d;

    // word forms: bit 31 over the top half
    assign wdata = alu_i.word ? {{32{alu_i.result[31]}}, alu_i.result[31:0]} : alu_i.result;

    always_comb begin
        case (alu_i.st_size)
            2'd0:    wmask = 8'h01;  // sb
            2'd1:    wmask = 8'h03;  // sh
            2'd2:    wmask = 8'h0f;  // sw
            default: wmask = 8'hff;  // sd
        endcase
    end

    // bytes outside the mask go out as zero
    always_comb begin
        for (int b = 0; b < XLEN/8; b++) begin
            sdata[8*b +: 8] = wmask[b] ? alu_i.sdata[8*b +: 8] : 8'h00;
        end
    end

    always_comb begin
        wb_d   = '0;
        jump_d = '0;
        mem_d  = '0;
        case (alu_i.kind)
            KIND_ALU: begin
                wb_d = '{wen: 1'b1, waddr: alu_i.rd, wdata: wdata};
            end
            KIND_JUMP: begin
                wb_d   = '{wen: 1'b1, waddr: alu_i.rd, wdata: wdata};  // link
                jump_d = '{en: 1'b1, addr: alu_i.addr};
            end
            KIND_BRANCH: begin
                // target shown even when not taken
                jump_d = '{en: alu_i.taken, addr: alu_i.addr};
            end
            KIND_STORE: begin
                mem_d = '{wen: 1'b1, waddr: alu_i.addr, wdata: sdata, wmask: wmask};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_o   <= '0;
            jump_o <= '0;
            mem_o  <= '0;
            pc_o   <= '0;
        end else begin
            wb_o   <= wb_d;
            jump_o <= jump_d;
            mem_o  <= mem_d;
            pc_o   <= alu_i.pc;  // pc tracks the bundle through all stages
        end
    end

endmodule

//--- src/ex_top.sv
`timescale 1ns/100ps

module ex_top import ex_pkg::*; (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic [INST_W-1:0] inst_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic [XLEN-1:0]   op1_i,
    input  logic [XLEN-1:0]   op2_i,
    input  logic [XLEN-1:0]   base_addr_i,
    input  logic [XLEN-1:0]   offset_addr_i,
    input  logic [REG_AW-1:0] rd_addr_i,
    output logic [XLEN-1:0]   rd_wdata_o,
    output logic [REG_AW-1:0] rd_waddr_o,
    output logic              reg_wen_o,
    output logic [XLEN-1:0]   inst_addr_o,
    output logic [XLEN-1:0]   jump_addr_o,
    output logic              jump_en_o,
    output logic              mem_wen_o,
    output logic [XLEN-1:0]   mem_waddr_o,
    output logic [XLEN-1:0]   mem_wdata_o,
    output logic [7:0]        mem_wmask_o
);

    ex_in_t  in_bus;
    dec_t    dec;
    alu_t    alu;
    wb_t     wb;
    jump_t   jump;
    mem_wr_t mem_wr;

    assign in_bus.inst   = inst_i;
    assign in_bus.pc     = pc_i;
    assign in_bus.op1    = op1_i;
    assign in_bus.op2    = op2_i;
    assign in_bus.rd     = rd_addr_i;
    assign in_bus.base   = base_addr_i;
    assign in_bus.offset = offset_addr_i;

    ex_decode u_decode (.clk_i(clk_i), .arst_n_i(arst_n_i), .in_i(in_bus), .dec_o(dec));

    ex_alu u_alu (.clk_i(clk_i), .arst_n_i(arst_n_i), .dec_i(dec), .alu_o(alu));

    ex_commit u_commit (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .alu_i    (alu),
        .wb_o     (wb),
        .jump_o   (jump),
        .mem_o    (mem_wr),
        .pc_o     (inst_addr_o)
    );

    assign rd_wdata_o  = wb.wdata;
    assign rd_waddr_o  = wb.waddr;
    assign reg_wen_o   = wb.wen;
    assign jump_addr_o = jump.addr;
    assign jump_en_o   = jump.en;
    assign mem_wen_o   = mem_wr.wen;
    assign mem_waddr_o = mem_wr.waddr;
    assign mem_wdata_o = mem_wr.wdata;
    assign mem_wmask_o = mem_wr.wmask;

endmodule

//--- verification/ex_tb_model.svh
`ifndef EX_TB_MODEL_SVH
`define EX_TB_MODEL_SVH

// expected top-level outputs for one bundle
typedef struct packed {
    logic              reg_wen;
    logic [REG_AW-1:0] rd_waddr;
    logic [XLEN-1:0]   rd_wdata;
    logic [XLEN-1:0]   inst_addr;
    logic              jump_en;
    logic [XLEN-1:0]   jump_addr;
    logic              mem_wen;
    logic [XLEN-1:0]   mem_waddr;
    logic [XLEN-1:0]   mem_wdata;
    logic [7:0]        mem_wmask;
} exp_t;

logic [31:0] lfsr_state = 32'd79;

// fibonacci lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit taken
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v          = {v[62:0], fb};
    end
    return v;
endfunction

// reference model, straight from the isa rules
function automatic exp_t predict(input ex_in_t s);
    exp_t            e;
    logic [31:0]     w;
    logic [2:0]      f3;
    logic            word;
    logic            wr;
    logic            ok;
    logic [5:0]      sh;
    logic [XLEN-1:0] r;
    logic [XLEN-1:0] usrc;
    logic [XLEN-1:0] ssrc;
    logic [XLEN-1:0] tgt;
    int              nb;
    e    = '0;
    w    = s.inst;
    f3   = w[14:12];
    word = (w[6:0] == OPC_OP_W) || (w[6:0] == OPC_OP_IMM_W);
    sh   = word ? {1'b0, s.op2[4:0]} : s.op2[5:0];
    usrc = word ? {32'b0, s.op1[31:0]} : s.op1;
    ssrc = word ? {{32{s.op1[31]}}, s.op1[31:0]} : s.op1;
    tgt  = s.base + s.offset;
    wr   = 1'b0;
    ok   = 1'b1;
    r    = '0;
    e.inst_addr = s.pc;  // pc rides along whatever the class
    case (w[6:0])
        OPC_OP, OPC_OP_W, OPC_OP_IMM, OPC_OP_IMM_W: begin
            wr = !word || f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5;
            case (f3)
                3'd0: r = (w[5] && w[30]) ? s.op1 - s.op2 : s.op1 + s.op2;  // opcode bit 5: reg op
                3'd1: r = s.op1 << sh;
                3'd2: r = {63'b0, $signed(s.op1) < $signed(s.op2)};
                3'd3: r = {63'b0, s.op1 < s.op2};
                3'd4: r = s.op1 ^ s.op2;
                3'd5: begin
                    if (w[30])
                        r = $signed(ssrc) >>> sh;
                    else
                        r = usrc >> sh;
                end
                3'd6: r = s.op1 | s.op2;
                default: r = s.op1 & s.op2;
            endcase
            if (word) r = {{32{r[31]}}, r[31:0]};
        end
        OPC_LUI: begin
            wr = 1'b1;
            r  = s.op2;
        end
        OPC_AUIPC: begin
            wr = 1'b1;
            r  = s.op1 + s.op2;
        end
        OPC_JAL, OPC_JALR: begin
            if (w[6:0] == OPC_JAL || f3 == 3'd0) begin
                wr          = 1'b1;
                r           = s.op1 + s.op2;  // link value
                e.jump_en   = 1'b1;
                e.jump_addr = tgt;
            end
        end
        OPC_BRANCH: begin
            case (f3)
                3'd0: e.jump_en = (s.op1 == s.op2);
                3'd1: e.jump_en = (s.op1 != s.op2);
                3'd4: e.jump_en = ($signed(s.op1) < $signed(s.op2));
                3'd5: e.jump_en = ($signed(s.op1) >= $signed(s.op2));
                3'd6: e.jump_en = (s.op1 < s.op2);
                3'd7: e.jump_en = (s.op1 >= s.op2);
                default: ok = 1'b0;
            endcase
            if (ok) e.jump_addr = tgt;  // target is visible even if not taken
        end
        OPC_STORE: begin
            if (!f3[2]) begin
                nb          = 1 << f3[1:0];
                e.mem_wen   = 1'b1;
                e.mem_waddr = tgt;
                e.mem_wmask = 8'((16'd1 << nb) - 16'd1);
                e.mem_wdata = s.op2 & ((64'd1 << (8 * nb)) - 64'd1);
            end
        end
        default: wr = 1'b0;
    endcase
    if (wr) begin
        e.reg_wen  = 1'b1;
        e.rd_waddr = s.rd;
        e.rd_wdata = r;
    end
    return e;
endfunction

`endif

//--- verification/ex_tb.sv
`timescale 1ns/100ps

module ex_tb import ex_pkg::*; ();

    localparam int N_NONE   = 10;
    localparam int N_ALU    = 48;
    localparam int N_WORD   = 32;
    localparam int N_BRANCH = 24;
    localparam int N_JUMP   = 16;
    localparam int N_MIX    = 32;
    localparam int DRAIN    = 4;  // idle bundles to empty the pipe
    localparam int RUN_LEN  = 10 + N_NONE + N_ALU + N_WORD + N_BRANCH + N_JUMP + N_MIX
                              + 6 * DRAIN;
    localparam int TIMEOUT  = RUN_LEN + 50;

    localparam logic [2:0] BR_F3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    localparam logic [6:0] JMP_OPC [4] = '{OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC};
    localparam logic [6:0] ALL_OPC [10] = '{OPC_OP_IMM, OPC_OP_IMM_W, OPC_OP, OPC_OP_W,
        OPC_BRANCH, OPC_STORE, OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC};

    `include "ex_tb_model.svh"

    logic              clk;
    logic              arst_n;
    ex_in_t            stim;
    logic [XLEN-1:0]   rd_wdata;
    logic [REG_AW-1:0] rd_waddr;
    logic              reg_wen;
    logic [XLEN-1:0]   inst_addr;
    logic [XLEN-1:0]   jump_addr;
    logic              jump_en;
    logic              mem_wen;
    logic [XLEN-1:0]   mem_waddr;
    logic [XLEN-1:0]   mem_wdata;
    logic [7:0]        mem_wmask;
    exp_t              exp_pipe [3];
    exp_t              exp_now;
    int                err_cnt = 0;
    int                err_mark = 0;
    int                tests_done = 0;
    int                checks = 0;
    int                cycle_cnt;

    ex_top u_dut (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .inst_i        (stim.inst),
        .pc_i          (stim.pc),
        .op1_i         (stim.op1),
        .op2_i         (stim.op2),
        .base_addr_i   (stim.base),
        .offset_addr_i (stim.offset),
        .rd_addr_i     (stim.rd),
        .rd_wdata_o    (rd_wdata),
        .rd_waddr_o    (rd_waddr),
        .reg_wen_o     (reg_wen),
        .inst_addr_o   (inst_addr),
        .jump_addr_o   (jump_addr),
        .jump_en_o     (jump_en),
        .mem_wen_o     (mem_wen),
        .mem_waddr_o   (mem_waddr),
        .mem_wdata_o   (mem_wdata),
        .mem_wmask_o   (mem_wmask)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected values delayed three edges to match the dut
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_pipe[0] <= '0;
            exp_pipe[1] <= '0;
            exp_pipe[2] <= '0;
        end else begin
            exp_pipe[0] <= predict(stim);
            exp_pipe[1] <= exp_pipe[0];
            exp_pipe[2] <= exp_pipe[1];
        end
    end

    assign exp_now = exp_pipe[2];

    always @(negedge clk) checks++;

    function automatic void report_mismatch(input string sig, input logic [63:0] want,
                                            input logic [63:0] got);
        $display("[FAIL] t=%0t %s expected %h actual %h", $time, sig, want, got);
        err_cnt++;
    endfunction

    // dut outputs change only on the rising edge
    a_reg_wen: assert property (@(negedge clk) reg_wen == exp_now.reg_wen)
        else report_mismatch("reg_wen_o", 64'(exp_now.reg_wen), 64'(reg_wen));
    a_rd_waddr: assert property (@(negedge clk) rd_waddr == exp_now.rd_waddr)
        else report_mismatch("rd_waddr_o", 64'(exp_now.rd_waddr), 64'(rd_waddr));
    a_rd_wdata: assert property (@(negedge clk) rd_wdata == exp_now.rd_wdata)
        else report_mismatch("rd_wdata_o", exp_now.rd_wdata, rd_wdata);
    a_inst_addr: assert property (@(negedge clk) inst_addr == exp_now.inst_addr)
        else report_mismatch("inst_addr_o", exp_now.inst_addr, inst_addr);
    a_jump_en: assert property (@(negedge clk) jump_en == exp_now.jump_en)
        else report_mismatch("jump_en_o", 64'(exp_now.jump_en), 64'(jump_en));
    a_jump_addr: assert property (@(negedge clk) jump_addr == exp_now.jump_addr)
        else report_mismatch("jump_addr_o", exp_now.jump_addr, jump_addr);
    a_mem_wen: assert property (@(negedge clk) mem_wen == exp_now.mem_wen)
        else report_mismatch("mem_wen_o", 64'(exp_now.mem_wen), 64'(mem_wen));
    a_mem_waddr: assert property (@(negedge clk) mem_waddr == exp_now.mem_waddr)
        else report_mismatch("mem_waddr_o", exp_now.mem_waddr, mem_waddr);
    a_mem_wdata: assert property (@(negedge clk) mem_wdata == exp_now.mem_wdata)
        else report_mismatch("mem_wdata_o", exp_now.mem_wdata, mem_wdata);
    a_mem_wmask: assert property (@(negedge clk) mem_wmask == exp_now.mem_wmask)
        else report_mismatch("mem_wmask_o", 64'(exp_now.mem_wmask), 64'(mem_wmask));

    function automatic logic [XLEN-1:0] pick_operand();
        logic [XLEN-1:0] v;
        v = rand_bits(XLEN);
        if (rand_bits(2) == 64'd0) begin
            v = {{56{v[7]}}, v[7:0]};  // small value of either sign
        end
        return v;
    endfunction

    function automatic ex_in_t rand_bundle(input logic [6:0] opc, input logic [2:0] f3);
        ex_in_t      s;
        logic [31:0] w;
        w        = 32'(rand_bits(32));
        w[6:0]   = opc;
        w[14:12] = f3;
        s.inst   = w;
        s.pc     = rand_bits(XLEN) & ~64'h3;
        s.op1    = pick_operand();
        s.op2    = pick_operand();
        s.rd     = REG_AW'(rand_bits(REG_AW));
        s.base   = rand_bits(XLEN);
        s.offset = {{52{w[31]}}, w[31:20]};
        return s;
    endfunction

    task automatic send(input ex_in_t s);
        @(negedge clk);
        stim = s;
    endtask

    task automatic close_test(input string name);
        repeat (DRAIN) send('0);
        tests_done++;
        $display("test %0d %s: %0d errors", tests_done, name, err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    task automatic idle_and_unknown();
        ex_in_t     s;
        logic [6:0] opc;
        for (int k = 0; k < N_NONE; k++) begin
            if (k == N_NONE - 2) begin
                s = rand_bundle(OPC_BRANCH, 3'b010);  // unused branch func3
            end else if (k == N_NONE - 1) begin
                s = rand_bundle(OPC_STORE, 3'b101);
            end else begin
                do begin
                    opc = 7'(rand_bits(7));
                end while (opc inside {OPC_OP_IMM, OPC_OP_IMM_W, OPC_OP, OPC_OP_W, OPC_BRANCH,
                                       OPC_STORE, OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC});
                s = rand_bundle(opc, 3'(rand_bits(3)));
            end
            send(s);
        end
        close_test("reset and unknown opcodes");
    endtask

    task automatic random_alu_ops(input logic word);
        ex_in_t      s;
        logic [31:0] w;
        logic [6:0]  opc;
        logic [2:0]  f3;
        for (int k = 0; k < (word ? N_WORD : N_ALU); k++) begin
            if (rand_bits(1) == 64'd1)
                opc = word ? OPC_OP_W : OPC_OP;
            else
                opc = word ? OPC_OP_IMM_W : OPC_OP_IMM;
            if (word)
                f3 = (k % 3 == 0) ? 3'd0 : (k % 3 == 1) ? 3'd1 : 3'd5;
            else
                f3 = 3'(rand_bits(3));
            s = rand_bundle(opc, f3);
            w = s.inst;
            if (opc[5]) begin
                w[31]    = 1'b0;  // func7 is 0 or 0x20
                w[29:25] = '0;
            end else begin
                s.op2 = s.offset;  // immediate operand
            end
            if (word && f3 == 3'd5 && k % 2 == 1) begin
                s.op1[31] = 1'b1;  // negative input to sraw or sraiw
                w[30]     = 1'b1;
            end
            s.inst = w;
            send(s);
        end
        close_test(word ? "word ops" : "random alu ops");
    endtask

    task automatic branches();
        ex_in_t s;
        for (int k = 0; k < N_BRANCH; k++) begin
            s = rand_bundle(OPC_BRANCH, BR_F3[k % 6]);
            if ((k / 6) % 2 == 1) s.op2 = s.op1;
            send(s);
        end
        close_test("branches");
    endtask

    task automatic jumps_and_upper();
        ex_in_t      s;
        logic [6:0]  opc;
        logic [31:0] w;
        for (int k = 0; k < N_JUMP; k++) begin
            opc = JMP_OPC[k % 4];
            s   = rand_bundle(opc, (opc == OPC_JALR) ? 3'd0 : 3'(rand_bits(3)));
            w   = s.inst;
            if (opc == OPC_LUI || opc == OPC_AUIPC) begin
                s.op2 = {{32{w[31]}}, w[31:12], 12'b0};
            end else begin
                s.op2 = 64'd4;  // link is pc + 4
            end
            if (opc != OPC_LUI) s.op1 = s.pc;
            send(s);
        end
        close_test("jumps, lui and auipc");
    endtask

    task automatic stores_and_mix();
        for (int k = 0; k < 8; k++) begin
            send(rand_bundle(OPC_STORE, 3'(k % 4)));
        end
        // back-to-back stream of every class
        for (int k = 8; k < N_MIX; k++) begin
            send(rand_bundle(ALL_OPC[int'(rand_bits(4)) % 10], 3'(rand_bits(3))));
        end
        close_test("stores and mixed stream");
    endtask

    initial begin
        arst_n = 1'b0;
        stim   = '0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        idle_and_unknown();
        random_alu_ops(1'b0);
        random_alu_ops(1'b1);
        branches();
        jumps_and_upper();
        stores_and_mix();
        $display("tests: %0d, cycles checked: %0d, errors: %0d", tests_done, checks, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("run timed out after %0d cycles", cycle_cnt);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- compile.f
+incdir+verification
src/ex_pkg.sv
src/ex_decode.sv
src/ex_alu.sv
src/ex_commit.sv
src/ex_top.sv
verification/ex_tb.sv
